/* all.f */
verilog/isa_pkg.sv
verilog/bpred_pkg.sv
verilog/pred_table.sv
verilog/dirp_local.sv
verilog/btb.sv
verilog/ras.sv
verilog/npc_control.sv
+incdir+dv
dv/npc_control_tb.sv

/* dv/bpred_model.svh */
/*
 * Reference model of the next-PC predictor, included inside the testbench.
 * Mirrors histories, counters, BTB and RAS, and gives expected outputs.
 */

`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

int unsigned m_hist [16];
int unsigned m_pht [256];
logic        m_btb_valid [16];
logic [31:0] m_btb_pc [16];
logic [31:0] m_btb_target [16];
logic [31:0] m_ras [$];

function automatic void model_reset();
    for (int i = 0; i < 16; i++) begin
        m_hist[i] = 0;
        m_btb_valid[i] = 1'b0;
    end
    for (int i = 0; i < 256; i++) begin
        m_pht[i] = 1;
    end
    m_ras.delete();
endfunction

// Word address bits 5:2
function automatic int unsigned slot(input logic [31:0] a);
    return (a >> 2) & 15;
endfunction

function automatic logic [7:0] exp_dirp_tag(input logic [31:0] a);
    return 8'((m_hist[slot(a)] << 4) | slot(a));
endfunction

function automatic logic btb_hits(input logic [31:0] a);
    return m_btb_valid[slot(a)] && ((m_btb_pc[slot(a)] >> 6) == (a >> 6));
endfunction

function automatic logic exp_predict(input logic [31:0] a, input logic br);
    return br && (m_pht[exp_dirp_tag(a)] >= 2) && btb_hits(a);
endfunction

function automatic logic [31:0] exp_npc(input logic [31:0] a, input logic br,
                                       input logic jp, input logic rt);
    if (rt && m_ras.size() > 0) begin
        return m_ras[m_ras.size()-1];
    end
    if ((jp && btb_hits(a)) || exp_predict(a, br)) begin
        return m_btb_target[slot(a)];
    end
    return a + 32'd4;
endfunction

function automatic int unsigned ctr_move(input int unsigned c, input logic up);
    if (up) begin
        return (c == 3) ? 3 : c + 1;
    end
    return (c == 0) ? 0 : c - 1;
endfunction

// State change at one rising edge
function automatic void model_edge(input logic [31:0] a, input logic jp, input logic rt,
                                   input logic sq, input branch_resolve_t r0,
                                   input branch_resolve_t r1, input fu_id_packet_t f0,
                                   input fu_id_packet_t f1);
    int unsigned n0;
    int unsigned n1;
    logic        pop;
    n0 = ctr_move(m_pht[r0.dirp_idx], r0.taken);
    n1 = ctr_move(m_pht[r1.dirp_idx], r1.taken);
    pop = rt && (m_ras.size() > 0);
    if (r0.valid) begin
        m_pht[r0.dirp_idx] = n0;
        m_hist[slot(r0.pc)] = (((r0.dirp_idx >> 4) << 1) | r0.taken) & 15;
    end
    if (r1.valid) begin
        m_pht[r1.dirp_idx] = n1;
        m_hist[slot(r1.pc)] = (((r1.dirp_idx >> 4) << 1) | r1.taken) & 15;
    end
    if (f0.is_valid && f0.is_branch) begin
        m_btb_valid[slot(f0.pc)] = 1'b1;
        m_btb_pc[slot(f0.pc)] = f0.pc;
        m_btb_target[slot(f0.pc)] = f0.target_pc;
    end
    if (f1.is_valid && f1.is_branch) begin
        m_btb_valid[slot(f1.pc)] = 1'b1;
        m_btb_pc[slot(f1.pc)] = f1.pc;
        m_btb_target[slot(f1.pc)] = f1.target_pc;
    end
    if (sq) begin
        m_ras.delete();
    end else if (jp && pop) begin
        m_ras[m_ras.size()-1] = a + 32'd4;
    end else if (jp) begin
        m_ras.push_back(a + 32'd4);
        // Oldest entry is lost once eight are held
        if (m_ras.size() > 8) begin
            void'(m_ras.pop_front());
        end
    end else if (pop) begin
        void'(m_ras.pop_back());
    end
endfunction

`endif

/* dv/npc_control_tb.sv */
/*
 * Testbench for the next-PC predictor. Drives directed and random fetch,
 * resolution and BTB fill traffic, and checks every cycle against a model.
 */

`timescale 1ns/10ps

module npc_control_tb
    import isa_pkg::*;
    import bpred_pkg::*;
;

    logic            clock = 1'b0;
    logic            rst_n;
    logic            squash;
    logic [31:0]     pc;
    logic            is_branch;
    logic            is_jump;
    logic            is_return;
    branch_resolve_t resolve_0;
    branch_resolve_t resolve_1;
    fu_id_packet_t   fu_id_0;
    fu_id_packet_t   fu_id_1;
    logic [31:0]     npc;
    logic            branch_predict;
    logic [7:0]      dirp_tag;

    int          errors;
    int          checks;
    int          tests_passed;
    int          tests_failed;
    int          test_errors_at_start;
    logic [15:0] lfsr_q;
    logic [31:0] pool [8];

    `include "bpred_model.svh"

    npc_control dut_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .pc             (pc),
        .is_branch      (is_branch),
        .is_jump        (is_jump),
        .is_return      (is_return),
        .resolve_0      (resolve_0),
        .resolve_1      (resolve_1),
        .fu_id_0        (fu_id_0),
        .fu_id_1        (fu_id_1),
        .npc            (npc),
        .branch_predict (branch_predict),
        .dirp_tag       (dirp_tag)
    );

    always #2 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_bit();
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Falling edge, then every input back to idle
    task automatic next_fall();
        @(negedge clock);
        squash = 1'b0;
        is_branch = 1'b0;
        is_jump = 1'b0;
        is_return = 1'b0;
        resolve_0 = '0;
        resolve_1 = '0;
        fu_id_0 = '0;
        fu_id_1 = '0;
    endtask

    task automatic fetch(input logic [31:0] a, input logic br, input logic jp,
                         input logic rt);
        next_fall();
        pc = a;
        is_branch = br;
        is_jump = jp;
        is_return = rt;
    endtask

    // Literal check of the current fetch, once inputs have settled
    task automatic expect_npc(input logic [31:0] exp, input logic exp_pred);
        #1;
        check_val("npc", exp, npc);
        check_val("branch_predict", 32'(exp_pred), 32'(branch_predict));
    endtask

    task automatic finish_test(input string name);
        int n;
        // Let the compare process finish this cycle
        @(posedge clock);
        n = errors - test_errors_at_start;
        $display("test %s: %0d errors", name, n);
        if (n == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        test_errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]     s_pc;
        logic            s_br;
        logic            s_jp;
        logic            s_rt;
        logic            s_sq;
        logic            s_rst_n;
        branch_resolve_t s_r0;
        branch_resolve_t s_r1;
        fu_id_packet_t   s_f0;
        fu_id_packet_t   s_f1;
        forever begin
            @(negedge clock);
            #1;
            s_pc = pc;
            s_br = is_branch;
            s_jp = is_jump;
            s_rt = is_return;
            s_sq = squash;
            s_rst_n = rst_n;
            s_r0 = resolve_0;
            s_r1 = resolve_1;
            s_f0 = fu_id_0;
            s_f1 = fu_id_1;
            if (s_rst_n) begin
                check_val("npc", exp_npc(s_pc, s_br, s_jp, s_rt), npc);
                check_val("branch_predict", 32'(exp_predict(s_pc, s_br)),
                          32'(branch_predict));
                check_val("dirp_tag", 32'(exp_dirp_tag(s_pc)), 32'(dirp_tag));
            end
            @(posedge clock);
            if (!s_rst_n) begin
                model_reset();
            end else begin
                model_edge(s_pc, s_jp, s_rt, s_sq, s_r0, s_r1, s_f0, s_f1);
            end
        end
    end

    // Bounds the whole run
    initial begin
        #200000;
        $display("timeout: simulation did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state_test();
        for (int i = 0; i < 8; i++) begin
            fetch(pool[i], 1'b0, 1'b0, 1'b1);
            expect_npc(pool[i] + 32'd4, 1'b0);
            fetch(pool[i], 1'b1, 1'b0, 1'b0);
            expect_npc(pool[i] + 32'd4, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            fetch(pool[i], 1'b0, 1'b1, 1'b0);
            expect_npc(pool[i] + 32'd4, 1'b0);
        end
        finish_test("reset_state");
    endtask

    task automatic btb_test();
        next_fall();
        fu_id_0 = '{is_valid: 1'b1, is_branch: 1'b1, pc: 32'h1040, target_pc: 32'h5000};
        fetch(32'h1040, 1'b0, 1'b1, 1'b0);
        expect_npc(32'h5000, 1'b0);
        // Same index, other tag
        fetch(32'h2040, 1'b0, 1'b1, 1'b0);
        expect_npc(32'h2044, 1'b0);
        next_fall();
        fu_id_0 = '{is_valid: 1'b1, is_branch: 1'b1, pc: 32'h1080, target_pc: 32'h6000};
        fu_id_1 = '{is_valid: 1'b1, is_branch: 1'b1, pc: 32'h1080, target_pc: 32'h7000};
        fetch(32'h1080, 1'b0, 1'b1, 1'b0);
        expect_npc(32'h7000, 1'b0);
        finish_test("btb_fill");
    endtask

    task automatic branch_test();
        logic [7:0] tag;
        next_fall();
        fu_id_1 = '{is_valid: 1'b1, is_branch: 1'b1, pc: 32'h1010, target_pc: 32'h3000};
        for (int i = 0; i < 7; i++) begin
            fetch(32'h1010, 1'b1, 1'b0, 1'b0);
            tag = exp_dirp_tag(32'h1010);
            next_fall();
            resolve_0 = '{valid: 1'b1, taken: 1'b1, pc: 32'h1010, dirp_idx: tag};
        end
        fetch(32'h1010, 1'b1, 1'b0, 1'b0);
        expect_npc(32'h3000, 1'b1);
        for (int i = 0; i < 8; i++) begin
            fetch(32'h1010, 1'b1, 1'b0, 1'b0);
            tag = exp_dirp_tag(32'h1010);
            next_fall();
            resolve_1 = '{valid: 1'b1, taken: 1'b0, pc: 32'h1010, dirp_idx: tag};
        end
        fetch(32'h1010, 1'b1, 1'b0, 1'b0);
        expect_npc(32'h1014, 1'b0);
        finish_test("branch_training");
    endtask

    task automatic ras_test();
        next_fall();
        squash = 1'b1;
        fetch(32'h100, 1'b0, 1'b1, 1'b0);
        fetch(32'h200, 1'b0, 1'b1, 1'b0);
        fetch(32'h300, 1'b0, 1'b1, 1'b0);
        fetch(32'h900, 1'b0, 1'b0, 1'b1);
        expect_npc(32'h304, 1'b0);
        fetch(32'h900, 1'b0, 1'b0, 1'b1);
        expect_npc(32'h204, 1'b0);
        fetch(32'h900, 1'b0, 1'b0, 1'b1);
        expect_npc(32'h104, 1'b0);
        for (int i = 0; i < 10; i++) begin
            fetch(32'h400 + 32'(i) * 32'h10, 1'b0, 1'b1, 1'b0);
        end
        // Only the newest eight survive
        for (int i = 9; i >= 2; i--) begin
            fetch(32'h900, 1'b0, 1'b0, 1'b1);
            expect_npc(32'h404 + 32'(i) * 32'h10, 1'b0);
        end
        fetch(32'h900, 1'b0, 1'b0, 1'b1);
        expect_npc(32'h904, 1'b0);
        fetch(32'h500, 1'b0, 1'b1, 1'b0);
        next_fall();
        squash = 1'b1;
        fetch(32'h900, 1'b0, 1'b0, 1'b1);
        expect_npc(32'h904, 1'b0);
        finish_test("return_stack");
    endtask

    task automatic random_test();
        int unsigned f;
        for (int i = 0; i < 400; i++) begin
            next_fall();
            pc = pool[rand_bits(3)];
            f = rand_bits(2);
            is_branch = (f == 1);
            is_jump = (f == 2);
            is_return = (f == 3);
            squash = (rand_bits(4) == 0);
            resolve_0.valid = rand_bits(1);
            resolve_0.taken = rand_bits(1);
            resolve_0.pc = pool[rand_bits(3)];
            resolve_0.dirp_idx = 8'(rand_bits(8));
            resolve_1.valid = rand_bits(1);
            resolve_1.taken = rand_bits(1);
            resolve_1.pc = pool[rand_bits(3)];
            resolve_1.dirp_idx = 8'(rand_bits(8));
            fu_id_0.is_valid = rand_bits(1);
            fu_id_0.is_branch = rand_bits(1);
            fu_id_0.pc = pool[rand_bits(3)];
            fu_id_0.target_pc = 32'h4000 + rand_bits(6) * 4;
            fu_id_1.is_valid = rand_bits(1);
            fu_id_1.is_branch = rand_bits(1);
            fu_id_1.pc = pool[rand_bits(3)];
            fu_id_1.target_pc = 32'h4000 + rand_bits(6) * 4;
        end
        next_fall();
        finish_test("random_mix");
    endtask

    initial begin
        rst_n = 1'b0;
        squash = 1'b0;
        pc = 32'h0;
        is_branch = 1'b0;
        is_jump = 1'b0;
        is_return = 1'b0;
        resolve_0 = '0;
        resolve_1 = '0;
        fu_id_0 = '0;
        fu_id_1 = '0;
        errors = 0;
        checks = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errors_at_start = 0;
        lfsr_q = 16'd63;
        // Several PCs share BTB and history slots
        pool = '{32'h1000, 32'h1004, 32'h1040, 32'h2040,
                 32'h1010, 32'h3010, 32'h100c, 32'h1044};
        for (int i = 0; i < 16; i++) begin
            @(negedge clock);
        end
        rst_n = 1'b1;
        reset_state_test();
        btb_test();
        branch_test();
        ras_test();
        random_test();
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog/npc_control.sv */
/*
 * Next-PC predictor of the fetch stage. Chooses between the RAS top,
 * the BTB target and PC plus 4 in the same cycle as the fetch PC.
 * Direction, target and return predictors are trained at the edge.
 */

`timescale 1ns/10ps

module npc_control
    import isa_pkg::*;
    import bpred_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    squash,

    // Fetch PC and predecode flags
    input  logic [XLEN-1:0]         pc,
    input  logic                    is_branch,
    input  logic                    is_jump,
    input  logic                    is_return,

    // Execute-stage resolutions
    input  branch_resolve_t         resolve_0,
    input  branch_resolve_t         resolve_1,

    // BTB fill packets
    input  fu_id_packet_t           fu_id_0,
    input  fu_id_packet_t           fu_id_1,

    output logic [XLEN-1:0]         npc,
    output logic                    branch_predict,
    output logic [DIRP_IDX_LEN-1:0] dirp_tag
);

    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] ras_pc;
    logic            btb_hit;
    logic            ras_valid;
    logic            dirp_taken;

    dirp_local dirp_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .is_branch (is_branch),
        .pc        (pc),
        .resolve_0 (resolve_0),
        .resolve_1 (resolve_1),
        .taken     (dirp_taken),
        .dirp_tag  (dirp_tag)
    );

    btb btb_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .pc      (pc),
        .fu_id_0 (fu_id_0),
        .fu_id_1 (fu_id_1),
        .target  (btb_target),
        .hit     (btb_hit)
    );

    ras ras_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .squash    (squash),
        .is_jump   (is_jump),
        .is_return (is_return),
        .pc        (pc),
        .return_pc (ras_pc),
        .valid     (ras_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Next-PC selection
    ////////////////////////////////////////////////////////////////////////////

    assign pc_plus_4 = pc + XLEN'(4);

    // Taken only with a known target
    assign branch_predict = dirp_taken && btb_hit;

    always_comb begin
        if (is_return && ras_valid) begin
            npc = ras_pc;
        end else if ((is_jump && btb_hit) || branch_predict) begin
            npc = btb_target;
        end else begin
            npc = pc_plus_4;
        end
    end

endmodule

/* verilog/ras.sv */
/*
 * Circular return address stack. Every jump pushes its fall-through
 * address, a return pops when the stack holds anything. When full, a
 * push overwrites the oldest entry. Squash empties it.
 */

`timescale 1ns/10ps

module ras
    import isa_pkg::*;
    import bpred_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,
    input  logic            squash,

    input  logic            is_jump,
    input  logic            is_return,
    input  logic [XLEN-1:0] pc,

    output logic [XLEN-1:0] return_pc,
    output logic            valid
);

    logic [XLEN-1:0] stack_q [RAS_DEPTH];

    logic [RAS_PTR_LEN-1:0] top_q;
    logic [RAS_PTR_LEN-1:0] push_idx;
    logic [RAS_PTR_LEN:0]   count_q;

    logic [XLEN-1:0] link_pc;
    logic            push;
    logic            pop;

    assign link_pc = pc + XLEN'(4);

    assign valid     = (count_q != '0);
    assign return_pc = stack_q[top_q];

    assign push = is_jump;
    assign pop  = is_return && valid;

    // Pop then push lands on the current top
    assign push_idx = pop ? top_q : top_q + 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Top pointer and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            top_q   <= '0;
            count_q <= '0;
        end else if (squash) begin
            count_q <= '0;
        end else if (push && !pop) begin
            top_q <= top_q + 1'b1;
            // Saturates, the oldest slot is reused
            if (count_q != (RAS_PTR_LEN+1)'(RAS_DEPTH)) begin
                count_q <= count_q + 1'b1;
            end
        end else if (pop && !push) begin
            top_q   <= top_q - 1'b1;
            count_q <= count_q - 1'b1;
        end
    end

    // Return addresses
    always_ff @(posedge clock) begin
        if (push && !squash) begin
            stack_q[push_idx] <= link_pc;
        end
    end

    a_count_bound: assert property (@(posedge clock) disable iff (!rst_n)
        count_q <= RAS_DEPTH);

    // A lone pop lowers occupancy and never wraps below zero
    a_pop_nonempty: assert property (@(posedge clock) disable iff (!rst_n)
        pop && !push && !squash |=> count_q < $past(count_q));

endmodule

/* verilog/btb.sv */
/*
 * Direct-mapped branch target buffer. Looked up combinationally with
 * the fetch PC, filled at the edge from two FU result packets.
 */

`timescale 1ns/10ps

module btb
    import isa_pkg::*;
    import bpred_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,

    // Lookup
    input  logic [XLEN-1:0] pc,

    // Fill from the functional units
    input  fu_id_packet_t   fu_id_0,
    input  fu_id_packet_t   fu_id_1,

    output logic [XLEN-1:0] target,
    output logic            hit
);

    btb_entry_t rd_entry;
    btb_entry_t wr_entry_0;
    btb_entry_t wr_entry_1;

    logic [BTB_TAG_LEN-1:0] pc_tag;

    // New valid entry from a resolved control transfer
    function automatic btb_entry_t make_entry(input fu_id_packet_t fu);
        btb_entry_t e;
        e.valid  = 1'b1;
        e.tag    = fu.pc[XLEN-1 -: BTB_TAG_LEN];
        e.target = fu.target_pc;
        return e;
    endfunction

    assign wr_entry_0 = make_entry(fu_id_0);
    assign wr_entry_1 = make_entry(fu_id_1);

    pred_table #(
        .payload_t   (btb_entry_t),
        .IDX_LEN     (BTB_IDX_LEN),
        .RESET_VALUE (btb_entry_t'('0))
    ) btb_table_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_idx    (pc[BTB_IDX_LEN+1:2]),
        .rd_data   (rd_entry),
        .wr_en_0   (fu_id_0.is_valid && fu_id_0.is_branch),
        .wr_idx_0  (fu_id_0.pc[BTB_IDX_LEN+1:2]),
        .wr_data_0 (wr_entry_0),
        .wr_en_1   (fu_id_1.is_valid && fu_id_1.is_branch),
        .wr_idx_1  (fu_id_1.pc[BTB_IDX_LEN+1:2]),
        .wr_data_1 (wr_entry_1)
    );

    // Aliased PCs share an index but not a tag
    assign pc_tag = pc[XLEN-1 -: BTB_TAG_LEN];
    assign hit    = rd_entry.valid && (rd_entry.tag == pc_tag);
    assign target = rd_entry.target;

endmodule

/* verilog/dirp_local.sv */
/*
 * Local-history direction predictor. A per-branch history table indexes
 * a pattern table of two-bit saturating counters together with PC bits.
 * Histories and counters are only written by execute-stage resolutions.
 */

`timescale 1ns/10ps

module dirp_local
    import isa_pkg::*;
    import bpred_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,

    // Fetch-side prediction
    input  logic                    is_branch,
    input  logic [XLEN-1:0]         pc,

    // Two resolutions per cycle
    input  branch_resolve_t         resolve_0,
    input  branch_resolve_t         resolve_1,

    output logic                    taken,
    output logic [DIRP_IDX_LEN-1:0] dirp_tag
);

    hist_entry_t fetch_hist;
    hist_entry_t hist_wr_0;
    hist_entry_t hist_wr_1;

    ctr_t pht_q [2**DIRP_IDX_LEN];
    ctr_t ctr_next_0;
    ctr_t ctr_next_1;

    // One saturating step toward the outcome
    function automatic ctr_t sat_step(input ctr_t ctr, input logic up);
        ctr_t nxt;
        nxt = ctr;
        if (up && ctr != CTR_MAX) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != CTR_MIN) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Local history table
    ////////////////////////////////////////////////////////////////////////////

    // History at prediction time rides in the upper bits of dirp_idx
    assign hist_wr_0 = '{hist: {resolve_0.dirp_idx[DIRP_IDX_LEN-2 -: HIST_LEN-1],
                                resolve_0.taken}};
    assign hist_wr_1 = '{hist: {resolve_1.dirp_idx[DIRP_IDX_LEN-2 -: HIST_LEN-1],
                                resolve_1.taken}};

    pred_table #(
        .payload_t   (hist_entry_t),
        .IDX_LEN     (HIST_IDX_LEN),
        .RESET_VALUE (hist_entry_t'('0))
    ) hist_table_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_idx    (pc[HIST_IDX_LEN+1:2]),
        .rd_data   (fetch_hist),
        .wr_en_0   (resolve_0.valid),
        .wr_idx_0  (resolve_0.pc[HIST_IDX_LEN+1:2]),
        .wr_data_0 (hist_wr_0),
        .wr_en_1   (resolve_1.valid),
        .wr_idx_1  (resolve_1.pc[HIST_IDX_LEN+1:2]),
        .wr_data_1 (hist_wr_1)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Pattern table
    ////////////////////////////////////////////////////////////////////////////

    assign dirp_tag = {fetch_hist.hist, pc[DIRP_PC_LEN+1:2]};
    assign taken    = is_branch && pht_q[dirp_tag][1];

    assign ctr_next_0 = sat_step(pht_q[resolve_0.dirp_idx], resolve_0.taken);
    assign ctr_next_1 = sat_step(pht_q[resolve_1.dirp_idx], resolve_1.taken);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**DIRP_IDX_LEN; i++) begin
                pht_q[i] <= CTR_WEAK_NT;
            end
        end else begin
            if (resolve_0.valid) begin
                pht_q[resolve_0.dirp_idx] <= ctr_next_0;
            end
            // Port 1 overrides on the same counter
            if (resolve_1.valid) begin
                pht_q[resolve_1.dirp_idx] <= ctr_next_1;
            end
        end
    end

    // Counter moves toward the outcome and never wraps around 0..3
    a_pht_step_0: assert property (@(posedge clock) disable iff (!rst_n)
        resolve_0.valid |-> (resolve_0.taken ? ctr_next_0 >= pht_q[resolve_0.dirp_idx]
                                             : ctr_next_0 <= pht_q[resolve_0.dirp_idx]));

    a_pht_step_1: assert property (@(posedge clock) disable iff (!rst_n)
        resolve_1.valid |-> (resolve_1.taken ? ctr_next_1 >= pht_q[resolve_1.dirp_idx]
                                             : ctr_next_1 <= pht_q[resolve_1.dirp_idx]));

endmodule

/* verilog/pred_table.sv */
/*
 * Direct-mapped register table with one combinational read port and
 * two write ports. The payload type is a parameter, so the same table
 * holds local histories and BTB entries. Port 1 wins on equal index.
 */

`timescale 1ns/10ps

module pred_table #(
    parameter type      payload_t   = logic [31:0],
    parameter int       IDX_LEN     = 4,
    parameter payload_t RESET_VALUE = '0
) (
    input  logic               clock,
    input  logic               rst_n,

    // Read port, same-cycle data
    input  logic [IDX_LEN-1:0] rd_idx,
    output payload_t           rd_data,

    // Write port 0
    input  logic               wr_en_0,
    input  logic [IDX_LEN-1:0] wr_idx_0,
    input  payload_t           wr_data_0,

    // Write port 1
    input  logic               wr_en_1,
    input  logic [IDX_LEN-1:0] wr_idx_1,
    input  payload_t           wr_data_1
);

    payload_t entry_q [2**IDX_LEN];

    // Reads see the state before this edge's writes
    assign rd_data = entry_q[rd_idx];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**IDX_LEN; i++) begin
                entry_q[i] <= RESET_VALUE;
            end
        end else begin
            if (wr_en_0) begin
                entry_q[wr_idx_0] <= wr_data_0;
            end
            // Later assignment takes effect on a collision
            if (wr_en_1) begin
                entry_q[wr_idx_1] <= wr_data_1;
            end
        end
    end

    // An unknown index would corrupt an arbitrary entry
    a_wr_idx_known_0: assert property (@(posedge clock) disable iff (!rst_n)
        wr_en_0 |-> !$isunknown(wr_idx_0));

    a_wr_idx_known_1: assert property (@(posedge clock) disable iff (!rst_n)
        wr_en_1 |-> !$isunknown(wr_idx_1));

endmodule

/* verilog/bpred_pkg.sv */
/*
 * Sizes, index widths and entry layouts of the branch predictors.
 * Used by the direction predictor, BTB, RAS and the next-PC top level.
 */

package bpred_pkg;

    import isa_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Branch target buffer
    ////////////////////////////////////////////////////////////////////////////

    // 16 entries, indexed by PC bits just above the byte offset
    localparam int BTB_IDX_LEN = 4;
    localparam int BTB_TAG_LEN = XLEN - BTB_IDX_LEN - 2;

    ////////////////////////////////////////////////////////////////////////////
    // Local direction predictor
    ////////////////////////////////////////////////////////////////////////////

    // 16 local history registers of 4 bits each
    localparam int HIST_IDX_LEN = 4;
    localparam int HIST_LEN     = 4;

    // Pattern index is {history, PC bits}, 256 counters
    localparam int DIRP_PC_LEN  = 4;
    localparam int DIRP_IDX_LEN = HIST_LEN + DIRP_PC_LEN;

    // Two-bit saturating counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MIN     = 2'd0;
    localparam ctr_t CTR_WEAK_NT = 2'd1;
    localparam ctr_t CTR_MAX     = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // Return address stack
    ////////////////////////////////////////////////////////////////////////////

    localparam int RAS_PTR_LEN = 3;
    localparam int RAS_DEPTH   = 2 ** RAS_PTR_LEN;

    ////////////////////////////////////////////////////////////////////////////
    // Entry and packet layouts
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic [BTB_TAG_LEN-1:0] tag;
        logic [XLEN-1:0]        target;
    } btb_entry_t;

    typedef struct packed {
        logic [HIST_LEN-1:0] hist;
    } hist_entry_t;

    // dirp_idx is the tag handed out with the prediction
    typedef struct packed {
        logic                    valid;
        logic                    taken;
        logic [XLEN-1:0]         pc;
        logic [DIRP_IDX_LEN-1:0] dirp_idx;
    } branch_resolve_t;

endpackage

/* verilog/isa_pkg.sv */
/*
 * ISA-level widths and the functional-unit result packet.
 * Shared by the next-PC predictor RTL and its testbench.
 */

package isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Machine width
    ////////////////////////////////////////////////////////////////////////////

    // RV32 address and data width
    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Functional-unit result packet
    ////////////////////////////////////////////////////////////////////////////

    // One per functional unit and cycle, no back-pressure
    // is_branch is set for any control transfer, jumps included
    typedef struct packed {
        logic            is_valid;
        logic            is_branch;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target_pc;
    } fu_id_packet_t;

endpackage
